// ==== source/fetch_pkg.sv ====
package fetch_pkg;

        // Branch history table geometry.
        localparam int BP_ENTRIES = 64;         // Table depth.
        localparam int BP_INDEX_W = 6;          // Log2 of BP_ENTRIES.

        // Thumb flag position in the CPSR.
        localparam int CPSR_T = 5;

        // Two-bit saturating branch state.
        typedef enum logic [1:0] {
                SNT = 2'd0,                     // Strongly not taken.
                WNT = 2'd1,                     // Weakly not taken.
                WT  = 2'd2,                     // Weakly taken.
                ST  = 2'd3                      // Strongly taken.
        } bp_state_t;

        // Pipeline control, highest priority first.
        typedef struct packed {
                logic clear_from_writeback;     // Flush from writeback.
                logic data_stall;               // Data cache stall.
                logic clear_from_alu;           // Branch mispredict flush.
                logic stall_from_shifter;       // Shifter busy.
                logic stall_from_issue;         // Issue busy.
                logic stall_from_decode;        // Decode busy.
                logic clear_from_decode;        // Flush from decode.
        } pipe_ctrl_t;

        // Packet handed to decode.
        typedef struct packed {
                logic [31:0] instruction;       // Straight from the cache.
                logic        valid;             // Packet holds an instruction.
                logic        instr_abort;       // Prefetch abort seen.
                logic [31:0] pc;                // Fetch address.
                logic [31:0] pc_plus_8;         // Architectural PC as read by code.
        } fetch_pkt_t;

        // Branch resolution from the ALU.
        typedef struct packed {
                logic        confirm;           // Prediction was right.
                logic [31:0] pc;                // Address of the branch.
                bp_state_t   taken;             // State that was predicted.
        } bp_update_t;

endpackage

// ==== source/bp_ram.sv ====
`timescale 1ns/1ps

module bp_ram
(
        input  logic                                i_clk,
        input  logic                                i_wr_en,
        input  logic [fetch_pkg::BP_INDEX_W-1:0]    i_wr_addr,
        input  logic [fetch_pkg::BP_INDEX_W-1:0]    i_rd_addr,
        input  fetch_pkg::bp_state_t                i_wr_data,
        output fetch_pkg::bp_state_t                o_rd_data
);

        // Branch history storage, no reset.
        fetch_pkg::bp_state_t mem [fetch_pkg::BP_ENTRIES];

        // Single clocked block.
        // A read that hits the entry being written returns the old state.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                begin
                        mem[i_wr_addr] <= i_wr_data;    // Write port.
                end
                o_rd_data <= mem[i_rd_addr];            // Registered read port.
        end

endmodule

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor
(
        input  logic                    i_clk,
        input  fetch_pkg::pipe_ctrl_t   i_ctrl,         // Only ALU clear and data stall used.
        input  logic [31:0]             i_pc,           // Fetch PC.
        input  fetch_pkg::bp_update_t   i_bp_update,    // Resolution from ALU.
        output fetch_pkg::bp_state_t    o_taken_ff      // State for previous fetch PC.
);

        logic [fetch_pkg::BP_INDEX_W-1:0] rd_addr;
        logic [fetch_pkg::BP_INDEX_W-1:0] wr_addr;
        logic                             wr_en;
        fetch_pkg::bp_state_t             next_state;

        // Halfword aligned index, bit 0 never set.
        assign rd_addr = i_pc[fetch_pkg::BP_INDEX_W:1];
        assign wr_addr = i_bp_update.pc[fetch_pkg::BP_INDEX_W:1];

        // Write on confirm or mispredict unless the memory stage stalls.
        assign wr_en = !i_ctrl.data_stall
                     && (i_ctrl.clear_from_alu || i_bp_update.confirm);

        // Saturating update. Mispredict takes precedence over confirm.
        always_comb
        begin
                if (i_ctrl.clear_from_alu)
                begin
                        unique case (i_bp_update.taken)
                                fetch_pkg::SNT: next_state = fetch_pkg::WNT;
                                fetch_pkg::WNT: next_state = fetch_pkg::WT;
                                fetch_pkg::WT:  next_state = fetch_pkg::WNT;
                                default:        next_state = fetch_pkg::WT; // Was ST.
                        endcase
                end
                else
                begin
                        unique case (i_bp_update.taken)
                                fetch_pkg::SNT: next_state = fetch_pkg::SNT;
                                fetch_pkg::WNT: next_state = fetch_pkg::SNT;
                                fetch_pkg::WT:  next_state = fetch_pkg::ST;
                                default:        next_state = fetch_pkg::ST; // Was ST.
                        endcase
                end
        end

        bp_ram u_bp_ram
        (
                .i_clk     (i_clk),
                .i_wr_en   (wr_en),
                .i_wr_addr (wr_addr),
                .i_rd_addr (rd_addr),
                .i_wr_data (next_state),
                .o_rd_data (o_taken_ff)
        );

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
(
        input  logic                    i_clk,
        input  logic                    i_reset,        // Synchronous, active high.
        input  fetch_pkg::pipe_ctrl_t   i_ctrl,         // Clears and stalls.
        input  logic [31:0]             i_pc,           // Fetch address.
        input  logic [31:0]             i_cpsr,         // For the Thumb bit.
        input  logic [31:0]             i_instruction,  // Cache read data.
        input  logic                    i_valid,        // Cache data strobe.
        input  logic                    i_instr_abort,  // Cache prefetch abort.
        output fetch_pkg::fetch_pkt_t   o_pkt           // To decode.
);

        logic        valid_ff;
        logic        abort_ff;
        logic        sleep_ff;          // Set after an abort, cleared by any flush.
        logic [31:0] pc_ff;
        logic [31:0] pc_plus_8_ff;
        logic [31:0] pc_plus_8;

        // PC as seen by the instruction. Thumb reads two halfwords ahead.
        assign pc_plus_8 = i_pc + (i_cpsr[fetch_pkg::CPSR_T] ? 32'd4 : 32'd8);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        valid_ff     <= 1'b0;
                        abort_ff     <= 1'b0;
                        sleep_ff     <= 1'b0;
                        pc_ff        <= 32'd0;
                        pc_plus_8_ff <= 32'd8;
                end
                else if (i_ctrl.clear_from_writeback)
                begin
                        valid_ff <= 1'b0;
                        abort_ff <= 1'b0;
                        sleep_ff <= 1'b0;       // Wake up.
                end
                else if (i_ctrl.data_stall)
                begin
                        // Hold everything.
                end
                else if (i_ctrl.clear_from_alu)
                begin
                        valid_ff <= 1'b0;
                        abort_ff <= 1'b0;
                        sleep_ff <= 1'b0;       // Wake up.
                end
                else if (i_ctrl.stall_from_shifter || i_ctrl.stall_from_issue
                         || i_ctrl.stall_from_decode)
                begin
                        // Back-pressure from later stages. Hold.
                end
                else if (i_ctrl.clear_from_decode)
                begin
                        valid_ff <= 1'b0;
                        abort_ff <= 1'b0;
                        sleep_ff <= 1'b0;       // Wake up.
                end
                else if (sleep_ff)
                begin
                        valid_ff <= 1'b0;       // Drop fetches until flushed.
                        abort_ff <= 1'b0;
                end
                else if (i_valid)
                begin
                        valid_ff     <= 1'b1;
                        abort_ff     <= i_instr_abort;
                        sleep_ff     <= i_instr_abort;  // Abort puts the stage to sleep.
                        pc_ff        <= i_pc;
                        pc_plus_8_ff <= pc_plus_8;
                end
                else
                begin
                        valid_ff <= 1'b0;       // Idle cycle.
                end
        end

        // Instruction bypasses the registers. Cache handles its own stalls.
        always_comb
        begin
                o_pkt.instruction = i_instruction;
                o_pkt.valid       = valid_ff;
                o_pkt.instr_abort = abort_ff;
                o_pkt.pc          = pc_ff;
                o_pkt.pc_plus_8   = pc_plus_8_ff;
        end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  fetch_pkg::pipe_ctrl_t   i_ctrl,         // Pipeline clears and stalls.
        input  logic [31:0]             i_pc,           // Fetch PC.
        input  logic [31:0]             i_cpsr,         // Current status register.
        input  logic [31:0]             i_instruction,  // Cache data.
        input  logic                    i_valid,        // Cache data valid.
        input  logic                    i_instr_abort,  // Cache abort.
        input  fetch_pkg::bp_update_t   i_bp_update,    // ALU branch resolution.
        output fetch_pkg::fetch_pkt_t   o_pkt,          // To decode.
        output fetch_pkg::bp_state_t    o_taken_ff      // Prediction for last fetch PC.
);

        // Instruction buffer.
        fetch_stage u_fetch_stage
        (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_ctrl        (i_ctrl),
                .i_pc          (i_pc),
                .i_cpsr        (i_cpsr),
                .i_instruction (i_instruction),
                .i_valid       (i_valid),
                .i_instr_abort (i_instr_abort),
                .o_pkt         (o_pkt)
        );

        // Branch history table, shares the fetch PC.
        branch_predictor u_branch_predictor
        (
                .i_clk       (i_clk),
                .i_ctrl      (i_ctrl),
                .i_pc        (i_pc),
                .i_bp_update (i_bp_update),
                .o_taken_ff  (o_taken_ff)
        );

endmodule

// ==== tb/fetch_assertions.sv ====
`timescale 1ns/1ps

module fetch_assertions
(
        input logic                     i_clk,
        input logic                     i_reset,
        input fetch_pkg::pipe_ctrl_t    i_ctrl,
        input fetch_pkg::fetch_pkt_t    i_pkt          // Packet of the top level.
);

        logic [31:0] pc_delta;

        assign pc_delta = i_pkt.pc_plus_8 - i_pkt.pc;  // ARM 8, Thumb 4.

        // Reset empties the buffer.
        valid_low_after_reset: assert property (@(posedge i_clk)
                i_reset |=> !i_pkt.valid)
                else $error("Packet valid right after reset.");

        // Data stall freezes every registered field.
        stall_holds_pkt: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_ctrl.data_stall && !i_ctrl.clear_from_writeback)
                |=> $stable({i_pkt.valid, i_pkt.instr_abort, i_pkt.pc, i_pkt.pc_plus_8}))
                else $error("Packet changed during a data stall.");

        pc_offset_legal: assert property (@(posedge i_clk) disable iff (i_reset)
                (pc_delta == 32'd4 || pc_delta == 32'd8))
                else $error("Pipeline PC offset is neither 4 nor 8.");

endmodule

bind fetch_top fetch_assertions u_fetch_assertions
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ctrl  (i_ctrl),
        .i_pkt   (o_pkt)
);

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

        // One trace line, inputs then expected outputs.
        typedef struct packed {
                logic [127:0]           name;
                fetch_pkg::pipe_ctrl_t  ctrl;
                logic [31:0]            pc;
                logic [31:0]            cpsr;
                logic                   valid;
                logic                   abort;
                fetch_pkg::bp_update_t  upd;
                logic                   exp_valid;
                logic                   exp_abort;
                logic [31:0]            exp_pc;
                logic [31:0]            exp_pc8;
                fetch_pkg::bp_state_t   exp_taken;
                logic                   chk_taken;      // Entry was written before.
        } trace_line_t;

        logic                   clk;
        logic                   reset;
        fetch_pkg::pipe_ctrl_t  ctrl;
        logic [31:0]            pc;
        logic [31:0]            cpsr;
        logic [31:0]            instruction;
        logic                   valid;
        logic                   instr_abort;
        fetch_pkg::bp_update_t  bp_update;
        fetch_pkg::fetch_pkt_t  pkt;
        fetch_pkg::bp_state_t   taken_ff;

        trace_line_t            trace_q [$];
        logic                   trace_loaded;
        logic [31:0]            lfsr_state;
        logic [31:0]            cur_instr;      // Word driven this cycle.
        integer                 check_count;
        integer                 value_errors;
        integer                 other_errors;
        integer                 i;

        fetch_top uut
        (
                .i_clk         (clk),
                .i_reset       (reset),
                .i_ctrl        (ctrl),
                .i_pc          (pc),
                .i_cpsr        (cpsr),
                .i_instruction (instruction),
                .i_valid       (valid),
                .i_instr_abort (instr_abort),
                .i_bp_update   (bp_update),
                .o_pkt         (pkt),
                .o_taken_ff    (taken_ff)
        );

        always #10 clk = ~clk;                  // 20 ns period.

        // Galois step, taps for x^32 + x^22 + x^2 + x + 1.
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                if (s[0])
                        lfsr_step = (s >> 1) ^ 32'h80200003;
                else
                        lfsr_step = s >> 1;
        endfunction

        // One LFSR step per bit.
        task automatic random_word(output logic [31:0] w);
                integer b;
                for (b = 0; b < 32; b++)
                begin
                        w[b] = lfsr_state[0];
                        lfsr_state = lfsr_step(lfsr_state);
                end
        endtask

        task automatic load_trace();
                integer      fd;
                integer      rc;
                logic [1599:0] header_line;
                logic [127:0] t_name;
                logic [31:0] t_ctrl, t_pc, t_cpsr, t_upc, t_epc, t_ep8;
                integer      t_vld, t_abt, t_cnf, t_utk, t_ev, t_ea, t_etk, t_ck;
                trace_line_t ln;
                fd = $fopen("tb/fetch_trace.txt", "r");
                if (fd == 0)
                begin
                        $display("Trace file tb/fetch_trace.txt could not be opened.");
                        other_errors++;
                end
                else
                begin
                        rc = $fgets(header_line, fd);   // Two column header lines.
                        rc = $fgets(header_line, fd);
                        while (!$feof(fd))
                        begin
                                rc = $fscanf(fd, "%s %h %h %h %d %d %d %h %d %d %d %h %h %d %d\n",
                                             t_name, t_ctrl, t_pc, t_cpsr, t_vld, t_abt, t_cnf,
                                             t_upc, t_utk, t_ev, t_ea, t_epc, t_ep8, t_etk, t_ck);
                                if (rc == 15)
                                begin
                                        ln.name         = t_name;
                                        ln.ctrl         = t_ctrl[6:0];
                                        ln.pc           = t_pc;
                                        ln.cpsr         = t_cpsr;
                                        ln.valid        = t_vld[0];
                                        ln.abort        = t_abt[0];
                                        ln.upd.confirm  = t_cnf[0];
                                        ln.upd.pc       = t_upc;
                                        ln.upd.taken    = fetch_pkg::bp_state_t'(t_utk[1:0]);
                                        ln.exp_valid    = t_ev[0];
                                        ln.exp_abort    = t_ea[0];
                                        ln.exp_pc       = t_epc;
                                        ln.exp_pc8      = t_ep8;
                                        ln.exp_taken    = fetch_pkg::bp_state_t'(t_etk[1:0]);
                                        ln.chk_taken    = t_ck[0];
                                        trace_q.push_back(ln);
                                end
                                else if (rc > 0)
                                begin
                                        $display("Trace line %0d is malformed.", trace_q.size() + 1);
                                        other_errors++;
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // Inputs change just after the edge.
        task automatic drive_line(input trace_line_t ln);
                logic [31:0] word;
                random_word(word);
                cur_instr    = word;
                ctrl        <= ln.ctrl;
                pc          <= ln.pc;
                cpsr        <= ln.cpsr;
                instruction <= word;
                valid       <= ln.valid;
                instr_abort <= ln.abort;
                bp_update   <= ln.upd;
        endtask

        task automatic drive_idle();
                ctrl        <= '0;
                valid       <= 1'b0;
                instr_abort <= 1'b0;
                bp_update   <= '0;
        endtask

        task automatic check_value(input logic [127:0] name, input logic [95:0] field,
                                   input logic [31:0] expv, input logic [31:0] actv);
                check_count++;
                if (expv !== actv)
                begin
                        $display("FAIL %0s %0s expected %h actual %h", name, field, expv, actv);
                        value_errors++;
                end
        endtask

        task automatic check_outputs(input trace_line_t ln);
                check_value(ln.name, "valid", ln.exp_valid, pkt.valid);
                check_value(ln.name, "abort", ln.exp_abort, pkt.instr_abort);
                check_value(ln.name, "pc", ln.exp_pc, pkt.pc);
                check_value(ln.name, "pc_plus_8", ln.exp_pc8, pkt.pc_plus_8);
                if (ln.chk_taken)
                        check_value(ln.name, "taken", ln.exp_taken, taken_ff);
        endtask

        // Watchdog, sized from the trace length.
        initial
        begin
                integer timeout_ns;
                wait (trace_loaded);
                timeout_ns = (trace_q.size() + 20) * 20;
                #(timeout_ns);
                $display("Timeout: the run did not finish within %0d ns.", timeout_ns);
                $display("Regression failed");
                $finish;
        end

        initial
        begin
                clk          = 1'b0;
                reset        = 1'b1;
                ctrl         = '0;
                pc           = '0;
                cpsr         = '0;
                instruction  = '0;
                valid        = 1'b0;
                instr_abort  = 1'b0;
                bp_update    = '0;
                cur_instr    = '0;
                lfsr_state   = 32'd91135;
                check_count  = 0;
                value_errors = 0;
                other_errors = 0;
                trace_loaded = 1'b0;
                load_trace();
                trace_loaded = 1'b1;
                repeat (3) @(posedge clk);      // Reset for 3 cycles.
                reset <= 1'b0;
                // Registered fields of a line show one edge after it is driven.
                for (i = 0; i < trace_q.size(); i++)
                begin
                        @(posedge clk);
                        drive_line(trace_q[i]);
                        @(negedge clk);
                        check_value(trace_q[i].name, "instruction", cur_instr, pkt.instruction);
                        if (i > 0)
                                check_outputs(trace_q[i - 1]);
                end
                if (trace_q.size() > 0)
                begin
                        @(posedge clk);
                        drive_idle();
                        @(negedge clk);
                        check_outputs(trace_q[trace_q.size() - 1]);
                end
                else
                begin
                        $display("No test lines were read from the trace.");
                        other_errors++;
                end
                $display("Closing report: %0d checks, %0d value errors, %0d other errors",
                         check_count, value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("Regression passed");
                else
                        $display("Regression failed");
                $finish;
        end

endmodule

// ==== tb/fetch_trace.txt ====
# name ctrl(hex: wb ds alu shf iss dstl dclr) pc cpsr valid abort confirm upd_pc upd_taken
# then expected: valid abort pc pc_plus_8 taken check_taken
fwd_arm       00 00001000 00000000 1 0 0 00000000 0 1 0 00001000 00001008 0 0
fwd_thumb     00 00001004 00000020 1 0 0 00000000 0 1 0 00001004 00001008 0 0
fwd_idle      00 00001008 00000000 0 0 0 00000000 0 0 0 00001004 00001008 0 0
fwd_arm2      00 00002000 00000000 1 0 0 00000000 0 1 0 00002000 00002008 0 0
fwd_thumb2    00 00002002 00000020 1 0 0 00000000 0 1 0 00002002 00002006 0 0
pri_wb_ds     60 00003000 00000000 1 0 0 00000000 0 0 0 00002002 00002006 0 0
pri_fetch     00 00003000 00000000 1 0 0 00000000 0 1 0 00003000 00003008 0 0
pri_ds_alu    30 00004000 00000000 1 0 0 00000000 3 1 0 00003000 00003008 0 0
pri_alu       10 00004000 00000000 1 0 0 00000000 0 0 0 00003000 00003008 0 0
pri_fetch2    00 00004000 00000000 1 0 0 00000000 0 1 0 00004000 00004008 0 0
pri_shift     08 00005000 00000000 1 0 0 00000000 0 1 0 00004000 00004008 0 0
pri_issue     04 00005000 00000000 1 0 0 00000000 0 1 0 00004000 00004008 0 0
pri_dec_stall 02 00005000 00000000 1 0 0 00000000 0 1 0 00004000 00004008 0 0
pri_dec_clr   01 00005000 00000000 1 0 0 00000000 0 0 0 00004000 00004008 0 0
pri_fetch3    00 00005000 00000020 1 0 0 00000000 0 1 0 00005000 00005004 0 0
abt_fetch     00 00006000 00000000 1 1 0 00000000 0 1 1 00006000 00006008 0 0
abt_sleep     00 00006004 00000000 1 0 0 00000000 0 0 0 00006000 00006008 0 0
abt_sleep2    00 00006008 00000000 1 0 0 00000000 0 0 0 00006000 00006008 0 0
abt_stall     08 00006008 00000000 1 0 0 00000000 0 0 0 00006000 00006008 0 0
abt_dec_wake  01 00006008 00000000 1 0 0 00000000 0 0 0 00006000 00006008 0 0
abt_resume    00 00007000 00000000 1 0 0 00000000 0 1 0 00007000 00007008 0 0
abt_fetch2    00 00007004 00000000 1 1 0 00000000 0 1 1 00007004 0000700c 0 0
abt_sleep3    00 00007008 00000000 1 0 0 00000000 0 0 0 00007004 0000700c 0 0
abt_wb_wake   40 00007008 00000000 1 0 0 00000000 0 0 0 00007004 0000700c 0 0
abt_resume2   00 00007010 00000020 1 0 0 00000000 0 1 0 00007010 00007014 0 0
bp_cnf_snt    00 00000000 00000000 0 0 1 00000102 0 0 0 00007010 00007014 1 1
bp_cnf_wnt    00 00000000 00000000 0 0 1 00000104 1 0 0 00007010 00007014 1 1
bp_cnf_wt     00 00000000 00000000 0 0 1 00000106 2 0 0 00007010 00007014 1 1
bp_cnf_st     00 00000000 00000000 0 0 1 00000108 3 0 0 00007010 00007014 1 1
bp_rd_cnf1    00 00000002 00000000 0 0 0 00000000 0 0 0 00007010 00007014 0 1
bp_rd_cnf2    00 00000004 00000000 0 0 0 00000000 0 0 0 00007010 00007014 0 1
bp_rd_cnf3    00 00000006 00000000 0 0 0 00000000 0 0 0 00007010 00007014 3 1
bp_rd_cnf4    00 00000008 00000000 0 0 0 00000000 0 0 0 00007010 00007014 3 1
bp_mis_snt    10 00000000 00000000 0 0 0 0000010a 0 0 0 00007010 00007014 1 1
bp_mis_wnt    10 00000000 00000000 0 0 0 0000010c 1 0 0 00007010 00007014 1 1
bp_mis_wt     10 00000000 00000000 0 0 0 0000010e 2 0 0 00007010 00007014 1 1
bp_mis_st     10 00000000 00000000 0 0 0 00000110 3 0 0 00007010 00007014 1 1
bp_rd_mis1    00 0000000a 00000000 0 0 0 00000000 0 0 0 00007010 00007014 1 1
bp_rd_mis2    00 0000000c 00000000 0 0 0 00000000 0 0 0 00007010 00007014 2 1
bp_rd_mis3    00 0000000e 00000000 0 0 0 00000000 0 0 0 00007010 00007014 1 1
bp_rd_mis4    00 00000010 00000000 0 0 0 00000000 0 0 0 00007010 00007014 2 1
bp_gate_cnf   20 00000000 00000000 0 0 1 00000102 2 0 0 00007010 00007014 1 1
bp_gate_alu   30 00000000 00000000 0 0 0 0000010a 3 0 0 00007010 00007014 1 1
bp_rd_gate1   00 00000002 00000000 0 0 0 00000000 0 0 0 00007010 00007014 0 1
bp_rd_gate2   00 0000000a 00000000 0 0 0 00000000 0 0 0 00007010 00007014 1 1
bp_collide    00 00000006 00000000 0 0 1 00000006 0 0 0 00007010 00007014 3 1
bp_rd_new     00 00000006 00000000 0 0 0 00000000 0 0 0 00007010 00007014 0 1
bp_rd_wrap    00 00000086 00000000 0 0 0 00000000 0 0 0 00007010 00007014 0 1

// ==== sources.f ====
source/fetch_pkg.sv
source/bp_ram.sv
source/branch_predictor.sv
source/fetch_stage.sv
source/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_buffer

sources:
  - source/fetch_pkg.sv
  - source/bp_ram.sv
  - source/branch_predictor.sv
  - source/fetch_stage.sv
  - source/fetch_top.sv
  - target: test
    files:
      - tb/fetch_assertions.sv
      - tb/fetch_tb.sv
